//--- rtl/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// reorder buffer geometry
`define ROB_SIZE     8
`define ROB_IDX_LEN  3

// data path and register index widths
`define XLEN         32
`define REG_IDX_LEN  5   // register 0 is never written

// execution lanes
`define NUM_LANES    2
`define LANE_DEPTH   3   // pipeline stages per lane

`endif

//--- rtl/ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_MUL = 3'd3,
        OP_BEQ = 3'd4   // predicted not taken
    } opcode_e;

    // one reorder buffer slot, 39 bits
    typedef struct packed {
        logic [`REG_IDX_LEN-1:0] dest_reg;
        logic [`XLEN-1:0]        value;
        logic                    ready;     // result written back
        logic                    mis_pred;  // branch resolved taken
    } rob_entry_t;

    // round-robin pointer of the dispatch unit, one value per lane
    typedef enum logic [0:0] {
        LANE_0 = 1'b0,
        LANE_1 = 1'b1
    } lane_sel_e;

endpackage

//--- rtl/lane_ifs.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

// dispatch to lane, single-cycle strobe, the lane always accepts
interface issue_if import ooo_pkg::*;
    ();
    logic                    valid;
    logic [`ROB_IDX_LEN-1:0] rob_idx;
    opcode_e                 opcode;
    logic [`XLEN-1:0]        op_a;
    logic [`XLEN-1:0]        op_b;

    modport dispatch (output valid, rob_idx, opcode, op_a, op_b);
    modport lane     (input  valid, rob_idx, opcode, op_a, op_b);

endinterface

// lane write-back into the reorder buffer
interface complete_if;
    logic                    valid;
    logic [`ROB_IDX_LEN-1:0] rob_idx;
    logic [`XLEN-1:0]        value;
    logic                    mis_pred;

    modport lane (output valid, rob_idx, value, mis_pred);
    modport rob  (input  valid, rob_idx, value, mis_pred);

endinterface

//--- rtl/dispatch_unit.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module dispatch_unit import ooo_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    inst_valid,
    input  opcode_e                 inst_opcode,
    input  logic [`XLEN-1:0]        inst_op_a,
    input  logic [`XLEN-1:0]        inst_op_b,
    input  logic [`REG_IDX_LEN-1:0] inst_dest,
    output logic                    inst_ready,

    input  logic [`ROB_IDX_LEN-1:0] rob_tail,
    input  logic                    rob_full,
    input  logic                    squash,
    output logic                    alloc,
    output logic [`REG_IDX_LEN-1:0] alloc_dest,

    issue_if.dispatch               issue [`NUM_LANES]
);

    lane_sel_e lane_sel;  // lane that takes the next instruction
    logic      accept;

    // nothing enters while the buffer is full or being flushed
    assign inst_ready = !rob_full && !squash;
    assign accept     = inst_valid && inst_ready;

    assign alloc      = accept;
    assign alloc_dest = inst_dest;

    // every lane sees the same payload, only the selected one gets the strobe
    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_issue
        assign issue[l].valid   = accept && (lane_sel == lane_sel_e'(l));
        assign issue[l].rob_idx = rob_tail;   // entry allocated this cycle
        assign issue[l].opcode  = inst_opcode;
        assign issue[l].op_a    = inst_op_a;
        assign issue[l].op_b    = inst_op_b;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lane_sel <= LANE_0;
        end else if (accept) begin
            // advance only when an instruction actually leaves
            if (lane_sel == lane_sel_e'(`NUM_LANES - 1)) begin
                lane_sel <= LANE_0;
            end else begin
                lane_sel <= lane_sel_e'(lane_sel + 1'b1);
            end
        end
    end

endmodule

//--- rtl/exec_lane.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module exec_lane import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,

    issue_if.lane     issue,
    complete_if.lane  done
);

    logic [`XLEN-1:0] result;
    logic             taken;

    // per-stage state, stage 0 holds the freshly computed result
    logic [`LANE_DEPTH-1:0]  stage_valid;
    logic [`LANE_DEPTH-1:0]  stage_mispred;
    logic [`XLEN-1:0]        stage_value [`LANE_DEPTH];
    logic [`ROB_IDX_LEN-1:0] stage_idx   [`LANE_DEPTH];

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (issue.opcode)
            OP_ADD:  result = issue.op_a + issue.op_b;
            OP_SUB:  result = issue.op_a - issue.op_b;
            OP_XOR:  result = issue.op_a ^ issue.op_b;
            OP_MUL:  result = issue.op_a * issue.op_b;  // low word of the product
            OP_BEQ:  taken  = (issue.op_a == issue.op_b);
            default: result = '0;
        endcase
    end

    // everything in flight is younger than the retiring branch, so drop it all
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[`LANE_DEPTH-2:0], issue.valid};
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            stage_value[0]   <= result;
            stage_idx[0]     <= issue.rob_idx;
            stage_mispred[0] <= taken;
        end
        for (int s = 1; s < `LANE_DEPTH; s++) begin
            stage_value[s]   <= stage_value[s-1];
            stage_idx[s]     <= stage_idx[s-1];
            stage_mispred[s] <= stage_mispred[s-1];
        end
    end

    assign done.valid    = stage_valid[`LANE_DEPTH-1];
    assign done.rob_idx  = stage_idx[`LANE_DEPTH-1];
    assign done.value    = stage_value[`LANE_DEPTH-1];
    assign done.mis_pred = stage_mispred[`LANE_DEPTH-1];

endmodule

//--- rtl/rob.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rob import ooo_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    alloc,
    input  logic [`REG_IDX_LEN-1:0] alloc_dest,
    output logic [`ROB_IDX_LEN-1:0] rob_tail,
    output logic                    rob_full,
    output logic                    squash,

    complete_if.rob                 done [`NUM_LANES],

    output logic                    retire_valid,
    output logic [`REG_IDX_LEN-1:0] retire_dest,
    output logic [`XLEN-1:0]        retire_value,
    output logic                    retire_reg_write,
    output logic                    retire_mispred
);

    logic [`ROB_IDX_LEN-1:0] rob_head;
    logic [`ROB_IDX_LEN:0]   rob_count;   // one bit wider so a full buffer fits
    rob_entry_t              entries [`ROB_SIZE];
    rob_entry_t              head_entry;
    logic                    rob_empty;

    // completion strobes flattened out of the interface array
    logic [`NUM_LANES-1:0]   cmp_valid;
    logic [`NUM_LANES-1:0]   cmp_mispred;
    logic [`ROB_IDX_LEN-1:0] cmp_idx   [`NUM_LANES];
    logic [`XLEN-1:0]        cmp_value [`NUM_LANES];

    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_done
        assign cmp_valid[l]   = done[l].valid;
        assign cmp_idx[l]     = done[l].rob_idx;
        assign cmp_value[l]   = done[l].value;
        assign cmp_mispred[l] = done[l].mis_pred;
    end

    // circular increment, the buffer size need not be a power of two
    function automatic logic [`ROB_IDX_LEN-1:0] next_idx(input logic [`ROB_IDX_LEN-1:0] idx);
        logic [`ROB_IDX_LEN-1:0] nxt;
        if (idx == `ROB_IDX_LEN'(`ROB_SIZE - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + 1'b1;
        end
        return nxt;
    endfunction

    assign head_entry = entries[rob_head];
    assign rob_empty  = (rob_count == '0);
    assign rob_full   = (rob_count == (`ROB_IDX_LEN+1)'(`ROB_SIZE));

    // head retires as soon as its result is back
    assign retire_valid     = !rob_empty && head_entry.ready;
    assign squash           = retire_valid && head_entry.mis_pred;
    assign retire_dest      = head_entry.dest_reg;
    assign retire_value     = head_entry.value;
    assign retire_reg_write = retire_valid && (head_entry.dest_reg != '0);
    assign retire_mispred   = squash;

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            rob_head  <= '0;
            rob_tail  <= '0;
            rob_count <= '0;
        end else if (squash) begin
            rob_head  <= rob_tail;   // drop every younger entry at once
            rob_count <= '0;
        end else begin
            if (alloc) begin
                rob_tail <= next_idx(rob_tail);
            end
            if (retire_valid) begin
                rob_head <= next_idx(rob_head);
            end
            case ({alloc, retire_valid})
                2'b10:   rob_count <= rob_count + 1'b1;
                2'b01:   rob_count <= rob_count - 1'b1;
                default: rob_count <= rob_count;
            endcase
        end
    end

    // entry storage, slots outside head..tail are never read
    always_ff @(posedge clock) begin
        if (!squash) begin
            if (alloc) begin
                entries[rob_tail] <= '{dest_reg: alloc_dest, value: '0,
                                       ready: 1'b0, mis_pred: 1'b0};
            end
            if (retire_valid) begin
                entries[rob_head] <= '0;
            end
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (cmp_valid[l]) begin
                    entries[cmp_idx[l]].ready    <= 1'b1;
                    entries[cmp_idx[l]].value    <= cmp_value[l];
                    entries[cmp_idx[l]].mis_pred <= cmp_mispred[l];
                end
            end
        end
    end

endmodule

//--- rtl/ooo_backend.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_backend import ooo_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    inst_valid,
    input  opcode_e                 inst_opcode,
    input  logic [`XLEN-1:0]        inst_op_a,
    input  logic [`XLEN-1:0]        inst_op_b,
    input  logic [`REG_IDX_LEN-1:0] inst_dest,
    output logic                    inst_ready,
    output logic [`ROB_IDX_LEN-1:0] inst_rob_idx,

    output logic                    retire_valid,
    output logic [`REG_IDX_LEN-1:0] retire_dest,
    output logic [`XLEN-1:0]        retire_value,
    output logic                    retire_reg_write,
    output logic                    retire_mispred
);

    logic                    alloc;
    logic [`REG_IDX_LEN-1:0] alloc_dest;
    logic [`ROB_IDX_LEN-1:0] rob_tail;
    logic                    rob_full;
    logic                    squash;

    issue_if    issue_bus [`NUM_LANES] ();
    complete_if done_bus  [`NUM_LANES] ();

    assign inst_rob_idx = rob_tail;   // index the presented instruction will get

    dispatch_unit dispatch_unit_inst (
        .clock, .reset,
        .inst_valid, .inst_opcode, .inst_op_a, .inst_op_b, .inst_dest, .inst_ready,
        .rob_tail, .rob_full, .squash, .alloc, .alloc_dest,
        .issue (issue_bus)
    );

    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
        exec_lane exec_lane_inst (
            .clock, .reset, .squash,
            .issue (issue_bus[l]),
            .done  (done_bus[l])
        );
    end

    rob rob_inst (
        .clock, .reset,
        .alloc, .alloc_dest, .rob_tail, .rob_full, .squash,
        .done (done_bus),
        .retire_valid, .retire_dest, .retire_value, .retire_reg_write, .retire_mispred
    );

endmodule

//--- dv/ooo_backend_tb.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_backend_tb import ooo_pkg::*; ();

    typedef struct packed {
        opcode_e                 opcode;
        logic [`XLEN-1:0]        op_a;
        logic [`XLEN-1:0]        op_b;
        logic [`REG_IDX_LEN-1:0] dest;
        logic [7:0]              gap;     // idle cycles before the row
        logic                    rand_b;  // op_b taken from the lfsr
        logic [3:0]              test;
    } row_t;

    typedef struct packed {
        logic [`XLEN-1:0]        value;
        logic [`REG_IDX_LEN-1:0] dest;
        logic                    mispred;
        logic [31:0]             cycle;   // cycle of the accepting edge sample
    } expect_t;

    logic clock, reset, inst_valid, inst_ready;
    opcode_e inst_opcode;
    logic [`XLEN-1:0] inst_op_a, inst_op_b, retire_value;
    logic [`REG_IDX_LEN-1:0] inst_dest, retire_dest;
    logic [`ROB_IDX_LEN-1:0] inst_rob_idx, ref_tail;
    logic retire_valid, retire_reg_write, retire_mispred;

    row_t        rows [32];
    expect_t     ref_q [$];
    expect_t     exp_e;
    string       test_names [5];
    logic [31:0] lfsr_state = 32'hbe86c2d5;
    int num_rows = 0, errors = 0, tests_passed = 0, cycle = 0, timeout_limit = 1000;
    int r, t, err_start;
    logic last_accept = 1'b0, exp_ready;

    ooo_backend ooo_backend_inst (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_random_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w          = {w[30:0], lfsr_state[0]};  // one step per bit
            lfsr_state = step_lfsr(lfsr_state);
        end
    endtask

    function automatic logic [`XLEN-1:0] expected_value(opcode_e op, logic [`XLEN-1:0] a,
                                                        logic [`XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            default: return '0;  // branch writes nothing useful
        endcase
    endfunction

    task automatic add_row(opcode_e op, logic [31:0] a, logic [31:0] b, logic [4:0] dest,
                           int gap, bit rnd, int test);
        rows[num_rows] = '{op, a, b, dest, gap[7:0], rnd, test[3:0]};
        num_rows++;
    endtask

    task automatic check_value(string name, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(string name, logic [`REG_IDX_LEN-1:0] got,
                              logic [`REG_IDX_LEN-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_index(string name, logic [`ROB_IDX_LEN-1:0] got,
                               logic [`ROB_IDX_LEN-1:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // outputs are settled mid-cycle, so the model samples on the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            exp_ready = (ref_q.size() != `ROB_SIZE) &&
                        !(retire_valid && ref_q.size() > 0 && ref_q[0].mispred);
            check_flag("inst_ready", inst_ready, exp_ready);
            if (retire_valid && ref_q.size() == 0) begin
                $display("retire seen with no instruction outstanding");
                errors++;
            end else if (retire_valid) begin
                exp_e = ref_q.pop_front();
                check_value("retire_value", retire_value, exp_e.value);
                check_dest("retire_dest", retire_dest, exp_e.dest);
                check_flag("retire_reg_write", retire_reg_write, exp_e.dest != '0);
                check_flag("retire_mispred", retire_mispred, exp_e.mispred);
                if (cycle < exp_e.cycle + 4) begin
                    $display("instruction retired before its result could complete");
                    errors++;
                end
                if (exp_e.mispred) ref_q.delete();  // younger work is flushed
            end else begin
                check_flag("retire_reg_write", retire_reg_write, 1'b0);
                check_flag("retire_mispred", retire_mispred, 1'b0);
            end
        end
        last_accept = inst_valid && inst_ready;
        if (last_accept) begin
            check_index("inst_rob_idx", inst_rob_idx, ref_tail);
            ref_tail = ref_tail + 1'b1;
            ref_q.push_back('{expected_value(inst_opcode, inst_op_a, inst_op_b), inst_dest,
                              (inst_opcode == OP_BEQ) && (inst_op_a == inst_op_b), cycle});
        end
    end

    task automatic apply_row(int idx);
        logic [31:0] b;
        b = rows[idx].op_b;
        if (rows[idx].rand_b) take_random_word(b);
        inst_valid = 1'b0;
        repeat (rows[idx].gap) begin
            @(posedge clock);
            #1;
        end
        inst_valid  = 1'b1;
        inst_opcode = rows[idx].opcode;
        inst_op_a   = rows[idx].op_a;
        inst_op_b   = b;
        inst_dest   = rows[idx].dest;
        @(posedge clock);
        while (!last_accept) @(posedge clock);  // hold until taken
        #1;
    endtask

    initial begin
        reset = 1'b1;
        inst_valid = 1'b0;
        inst_opcode = OP_ADD;
        inst_op_a = '0;
        inst_op_b = '0;
        inst_dest = '0;
        ref_tail = '0;
        test_names = '{"alu back to back", "writes to r0", "beq not taken", "beq taken",
                       "burst"};
        //      opcode  op_a           op_b           dest  gap rnd test
        add_row(OP_ADD, 32'd5,         32'd7,         5'd1,  3, 0, 0);
        add_row(OP_SUB, 32'd10,        32'd3,         5'd2,  0, 0, 0);
        add_row(OP_XOR, 32'hf0f0_1234, 32'h0ff0_4321, 5'd3,  0, 0, 0);
        add_row(OP_MUL, 32'h0001_0003, 32'h0,         5'd4,  0, 1, 0);
        add_row(OP_SUB, 32'd0,         32'd1,         5'd5,  0, 0, 0);
        add_row(OP_ADD, 32'd1,         32'd2,         5'd0,  2, 0, 1);
        add_row(OP_MUL, 32'h1234_5678, 32'h0,         5'd0,  0, 1, 1);
        add_row(OP_XOR, 32'haaaa_aaaa, 32'h5555_5555, 5'd6,  1, 0, 1);
        add_row(OP_BEQ, 32'd1,         32'd2,         5'd0,  2, 0, 2);
        add_row(OP_ADD, 32'd100,       32'd200,       5'd7,  0, 0, 2);
        add_row(OP_SUB, 32'd7,         32'd9,         5'd8,  0, 0, 2);
        add_row(OP_BEQ, 32'd9,         32'd9,         5'd0,  2, 0, 3);
        add_row(OP_ADD, 32'd1,         32'd1,         5'd9,  0, 0, 3);  // squashed
        add_row(OP_ADD, 32'd2,         32'd2,         5'd10, 0, 0, 3);  // squashed
        add_row(OP_ADD, 32'd3,         32'd3,         5'd11, 0, 0, 3);  // squashed
        add_row(OP_XOR, 32'hdead_beef, 32'hffff_0000, 5'd12, 0, 0, 3);
        add_row(OP_SUB, 32'd50,        32'd8,         5'd13, 0, 0, 3);
        for (int i = 0; i < 12; i++) begin
            add_row(opcode_e'(i % 4), 32'h100 * (i + 1), 32'd3 * i, 5'(i + 1), 0, i[0], 4);
        end
        timeout_limit = 20 * num_rows + 100;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        r = 0;
        for (t = 0; t < 5; t++) begin
            err_start = errors;
            while (r < num_rows && rows[r].test == t) begin
                apply_row(r);
                r++;
            end
            inst_valid = 1'b0;
            @(posedge clock);
            while (ref_q.size() != 0) @(posedge clock);  // let the test drain
            #1;
            if (errors == err_start) tests_passed++;
            $display("test %0d %s: %s", t, test_names[t], errors == err_start ? "ok" : "failed");
        end
        $display("tests run 5, passed %0d, errors %0d", tests_passed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- ooo_backend.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/lane_ifs.sv
rtl/dispatch_unit.sv
rtl/exec_lane.sv
rtl/rob.sv
rtl/ooo_backend.sv
dv/ooo_backend_tb.sv
